// File: Makefile
TOP = tb_valu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir

// File: hw/valu_insn_queue.sv
module valu_insn_queue #(
  parameter int unsigned InsnQueueDepth = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Instruction port
  input  logic                         insn_valid_i,
  input  valu_pkg::alu_op_e            insn_op_i,
  input  valu_pkg::vew_e               insn_vsew_i,
  input  valu_pkg::vlen_t              insn_vl_i,
  input  valu_pkg::vreg_t              insn_vd_i,
  input  valu_pkg::vid_t               insn_id_i,
  input  logic                         insn_vm_i,
  input  logic                         insn_use_scalar_i,
  input  valu_pkg::elen_t              insn_scalar_i,
  output logic                         insn_ready_o,
  // Operand and mask handshakes
  input  logic [1:0]                   operand_valid_i,
  output logic [1:0]                   operand_ready_o,
  input  logic                         mask_valid_i,
  output logic                         mask_ready_o,
  // Result queue status
  input  logic                         rq_full_i,
  input  logic                         commit_i,
  // Word issue and the instruction being issued
  output logic                         issue_o,
  output valu_pkg::alu_op_e            iss_op_o,
  output valu_pkg::vew_e               iss_vsew_o,
  output valu_pkg::vlen_t              iss_vl_o,
  output valu_pkg::vreg_t              iss_vd_o,
  output valu_pkg::vid_t               iss_id_o,
  output logic                         iss_vm_o,
  output logic                         iss_use_scalar_o,
  output valu_pkg::elen_t              iss_scalar_o,
  output valu_pkg::vlen_t              iss_remaining_o,
  output logic [valu_pkg::NrVInsn-1:0] done_o
);

  localparam int unsigned PntBits = $clog2(InsnQueueDepth);

  typedef logic [PntBits-1:0] pnt_t;
  typedef logic [PntBits:0]   cnt_t;

  // Circular increment of a queue pointer
  function automatic pnt_t bump(pnt_t pnt);
    return (pnt == pnt_t'(InsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Instruction storage
  valu_pkg::alu_op_e op_q         [InsnQueueDepth];
  valu_pkg::vew_e    vsew_q       [InsnQueueDepth];
  valu_pkg::vlen_t   vl_q         [InsnQueueDepth];
  valu_pkg::vreg_t   vd_q         [InsnQueueDepth];
  valu_pkg::vid_t    id_q         [InsnQueueDepth];
  logic              vm_q         [InsnQueueDepth];
  logic              use_scalar_q [InsnQueueDepth];
  valu_pkg::elen_t   scalar_q     [InsnQueueDepth];

  // Accept, issue and commit phases each keep a pointer
  pnt_t accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions still waiting to issue or to commit
  cnt_t issue_cnt_q, issue_cnt_d;
  cnt_t commit_cnt_q, commit_cnt_d;
  // Elements left in the head instruction of each phase
  valu_pkg::vlen_t issue_rem_q, issue_rem_d;
  valu_pkg::vlen_t commit_rem_q, commit_rem_d;
  valu_pkg::vlen_t issue_step, commit_step;

  logic accept;
  logic issue_valid;
  logic issue_last;
  logic commit_last;

  assign insn_ready_o = (commit_cnt_q != cnt_t'(InsnQueueDepth));
  assign accept       = insn_valid_i && insn_ready_o;
  assign issue_valid  = (issue_cnt_q != '0);

  // Head of the issue phase
  assign iss_op_o         = op_q[issue_pnt_q];
  assign iss_vsew_o       = vsew_q[issue_pnt_q];
  assign iss_vl_o         = vl_q[issue_pnt_q];
  assign iss_vd_o         = vd_q[issue_pnt_q];
  assign iss_id_o         = id_q[issue_pnt_q];
  assign iss_vm_o         = vm_q[issue_pnt_q];
  assign iss_use_scalar_o = use_scalar_q[issue_pnt_q];
  assign iss_scalar_o     = scalar_q[issue_pnt_q];
  assign iss_remaining_o  = issue_rem_q;

  //////////////////////////////////////////////////
  // Word issue
  //////////////////////////////////////////////////

  // Operand b always, a only for vector-vector, mask only when vm is low
  assign issue_o = issue_valid && !rq_full_i && operand_valid_i[1] &&
                   (operand_valid_i[0] || iss_use_scalar_o) &&
                   (mask_valid_i || iss_vm_o);

  // Operands are consumed in the issue cycle
  assign operand_ready_o = {issue_o, issue_o && !iss_use_scalar_o};
  assign mask_ready_o    = issue_o && !iss_vm_o;

  always_comb begin : p_issue
    // At most one word of elements per issue
    issue_step = valu_pkg::elems_per_word(iss_vsew_o);
    if (issue_step > issue_rem_q) begin
      issue_step = issue_rem_q;
    end
    issue_last  = issue_o && (issue_rem_q == issue_step);
    issue_cnt_d = issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_last);

    issue_rem_d = issue_rem_q;
    if (issue_o) begin
      issue_rem_d = issue_rem_q - issue_step;
    end
    // Move on to the next stored instruction
    if (issue_last && issue_cnt_q > cnt_t'(1)) begin
      issue_rem_d = vl_q[bump(issue_pnt_q)];
    end
    // New instruction lands at the head
    if (accept && issue_cnt_d == cnt_t'(1)) begin
      issue_rem_d = insn_vl_i;
    end
  end

  //////////////////////////////////////////////////
  // Commit and done pulses
  //////////////////////////////////////////////////

  always_comb begin : p_commit
    commit_step  = valu_pkg::elems_per_word(vsew_q[commit_pnt_q]);
    commit_rem_d = commit_rem_q;
    // Saturate at zero on the tail word
    if (commit_i) begin
      commit_rem_d = (commit_rem_q > commit_step) ? commit_rem_q - commit_step : '0;
    end
    commit_last  = commit_i && (commit_cnt_q != '0) && (commit_rem_d == '0);
    commit_cnt_d = commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_last);

    if (commit_last && commit_cnt_q > cnt_t'(1)) begin
      commit_rem_d = vl_q[bump(commit_pnt_q)];
    end
    if (accept && commit_cnt_d == cnt_t'(1)) begin
      commit_rem_d = insn_vl_i;
    end

    // Same cycle as the grant of the last word
    done_o = '0;
    if (commit_last) begin
      done_o[id_q[commit_pnt_q]] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      issue_rem_q  <= '0;
      commit_rem_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (issue_last) begin
        issue_pnt_q <= bump(issue_pnt_q);
      end
      if (commit_last) begin
        commit_pnt_q <= bump(commit_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      issue_rem_q  <= issue_rem_d;
      commit_rem_q <= commit_rem_d;
    end
  end

  // Instruction fields written at the accept pointer
  always_ff @(posedge clk_i) begin : p_storage
    if (accept) begin
      op_q[accept_pnt_q]         <= insn_op_i;
      vsew_q[accept_pnt_q]       <= insn_vsew_i;
      vl_q[accept_pnt_q]         <= insn_vl_i;
      vd_q[accept_pnt_q]         <= insn_vd_i;
      id_q[accept_pnt_q]         <= insn_id_i;
      vm_q[accept_pnt_q]         <= insn_vm_i;
      use_scalar_q[accept_pnt_q] <= insn_use_scalar_i;
      scalar_q[accept_pnt_q]     <= insn_scalar_i;
    end
  end

endmodule

// File: hw/valu_pkg.sv
package valu_pkg;

  // Datapath word and its byte enables
  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = ElenBits / 8;

  typedef logic [ElenBits-1:0] elen_t;
  typedef logic [StrbBits-1:0] strb_t;

  // Instruction IDs, one done bit each
  localparam int unsigned NrVInsn = 8;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Element count, up to 512 elements
  typedef logic [9:0] vlen_t;

  // Register file words held by this lane per vector register
  localparam int unsigned VRegWords = 64;

  typedef logic [10:0] vaddr_t;
  typedef logic [4:0]  vreg_t;

  // Elementwise integer operations
  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VRSUB,
    VAND,
    VOR,
    VXOR,
    VMINU,
    VMAXU
  } alu_op_e;

  // Element width
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Elements packed into one 64-bit word: 8, 4, 2 or 1
  function automatic vlen_t elems_per_word(vew_e vsew);
    return vlen_t'(8) >> vsew;
  endfunction

endpackage

// File: hw/valu_result_queue.sv
module valu_result_queue #(
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Entry written on word issue
  input  logic             push_i,
  input  valu_pkg::vid_t   id_i,
  input  valu_pkg::vaddr_t addr_i,
  input  valu_pkg::elen_t  wdata_i,
  input  valu_pkg::strb_t  be_i,
  output logic             full_o,
  output logic             commit_o,
  // Register file write port
  output logic             result_req_o,
  output valu_pkg::vid_t   result_id_o,
  output valu_pkg::vaddr_t result_addr_o,
  output valu_pkg::elen_t  result_wdata_o,
  output valu_pkg::strb_t  result_be_o,
  input  logic             result_gnt_i
);

  localparam int unsigned PntBits = $clog2(ResultQueueDepth);

  typedef logic [PntBits-1:0] pnt_t;
  typedef logic [PntBits:0]   cnt_t;

  function automatic pnt_t bump(pnt_t pnt);
    return (pnt == pnt_t'(ResultQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Entry payload
  valu_pkg::vid_t   id_q    [ResultQueueDepth];
  valu_pkg::vaddr_t addr_q  [ResultQueueDepth];
  valu_pkg::elen_t  wdata_q [ResultQueueDepth];
  valu_pkg::strb_t  be_q    [ResultQueueDepth];

  pnt_t wr_pnt_q, rd_pnt_q;
  cnt_t cnt_q;

  assign full_o       = (cnt_q == cnt_t'(ResultQueueDepth));
  // Request held while any entry waits
  assign result_req_o = (cnt_q != '0);
  // Grant pops the head and retires its elements
  assign commit_o     = result_req_o && result_gnt_i;

  // Head entry drives the write port
  assign result_id_o    = id_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptr_ff
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= bump(wr_pnt_q);
      end
      if (commit_o) begin
        rd_pnt_q <= bump(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(commit_o);
    end
  end

  // Issue never pushes into a full queue
  always_ff @(posedge clk_i) begin : p_entry_ff
    if (push_i) begin
      id_q[wr_pnt_q]    <= id_i;
      addr_q[wr_pnt_q]  <= addr_i;
      wdata_q[wr_pnt_q] <= wdata_i;
      be_q[wr_pnt_q]    <= be_i;
    end
  end

endmodule

// File: hw/valu_simd_alu.sv
module valu_simd_alu (
  input  valu_pkg::alu_op_e op_i,
  input  valu_pkg::vew_e    vsew_i,
  input  logic              use_scalar_i,
  input  valu_pkg::elen_t   scalar_i,
  input  valu_pkg::elen_t   operand_a_i,
  input  valu_pkg::elen_t   operand_b_i,
  output valu_pkg::elen_t   result_o
);

  // One element, zero-extended to a full word; caller truncates
  function automatic valu_pkg::elen_t elem_op(valu_pkg::alu_op_e op,
                                              valu_pkg::elen_t a,
                                              valu_pkg::elen_t b);
    unique case (op)
      valu_pkg::VADD:  return a + b;
      valu_pkg::VSUB:  return b - a;
      valu_pkg::VRSUB: return a - b;
      valu_pkg::VAND:  return a & b;
      valu_pkg::VOR:   return a | b;
      valu_pkg::VXOR:  return a ^ b;
      // Unsigned compare is exact on zero-extended elements
      valu_pkg::VMINU: return (a < b) ? a : b;
      valu_pkg::VMAXU: return (a > b) ? a : b;
      default:         return '0;
    endcase
  endfunction

  valu_pkg::elen_t scalar_rep;
  valu_pkg::elen_t opa;

  //////////////////////////////////////////////////
  // Scalar replication
  //////////////////////////////////////////////////

  // Low element of the scalar copied into every lane
  always_comb begin : p_scalar
    unique case (vsew_i)
      valu_pkg::EW8:  scalar_rep = {8{scalar_i[7:0]}};
      valu_pkg::EW16: scalar_rep = {4{scalar_i[15:0]}};
      valu_pkg::EW32: scalar_rep = {2{scalar_i[31:0]}};
      default:        scalar_rep = scalar_i;
    endcase
  end

  // Scalar takes the place of operand a
  assign opa = use_scalar_i ? scalar_rep : operand_a_i;

  //////////////////////////////////////////////////
  // SIMD datapath
  //////////////////////////////////////////////////

  // Each lane computed alone, so no carry crosses an element boundary
  always_comb begin : p_simd
    result_o = '0;
    unique case (vsew_i)
      valu_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          result_o[8*i +: 8] = 8'(elem_op(op_i, valu_pkg::elen_t'(opa[8*i +: 8]),
                                          valu_pkg::elen_t'(operand_b_i[8*i +: 8])));
        end
      end
      valu_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          result_o[16*i +: 16] = 16'(elem_op(op_i, valu_pkg::elen_t'(opa[16*i +: 16]),
                                             valu_pkg::elen_t'(operand_b_i[16*i +: 16])));
        end
      end
      valu_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          result_o[32*i +: 32] = 32'(elem_op(op_i, valu_pkg::elen_t'(opa[32*i +: 32]),
                                             valu_pkg::elen_t'(operand_b_i[32*i +: 32])));
        end
      end
      default: begin
        result_o = elem_op(op_i, opa, operand_b_i);
      end
    endcase
  end

endmodule

// File: hw/valu_top.sv
module valu_top #(
  parameter int unsigned InsnQueueDepth   = 4,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Instruction port
  input  logic                         insn_valid_i,
  input  valu_pkg::alu_op_e            insn_op_i,
  input  valu_pkg::vew_e               insn_vsew_i,
  input  valu_pkg::vlen_t              insn_vl_i,
  input  valu_pkg::vreg_t              insn_vd_i,
  input  valu_pkg::vid_t               insn_id_i,
  input  logic                         insn_vm_i,
  input  logic                         insn_use_scalar_i,
  input  valu_pkg::elen_t              insn_scalar_i,
  output logic                         insn_ready_o,
  output logic [valu_pkg::NrVInsn-1:0] done_o,
  // Operand queues
  input  valu_pkg::elen_t              operand_a_i,
  input  valu_pkg::elen_t              operand_b_i,
  input  logic [1:0]                   operand_valid_i,
  output logic [1:0]                   operand_ready_o,
  // Mask operand
  input  valu_pkg::strb_t              mask_i,
  input  logic                         mask_valid_i,
  output logic                         mask_ready_o,
  // Register file write port
  output logic                         result_req_o,
  output valu_pkg::vid_t               result_id_o,
  output valu_pkg::vaddr_t             result_addr_o,
  output valu_pkg::elen_t              result_wdata_o,
  output valu_pkg::strb_t              result_be_o,
  input  logic                         result_gnt_i
);

  // Issue side
  logic              issue;
  valu_pkg::alu_op_e iss_op;
  valu_pkg::vew_e    iss_vsew;
  valu_pkg::vlen_t   iss_vl;
  valu_pkg::vreg_t   iss_vd;
  valu_pkg::vid_t    iss_id;
  logic              iss_vm;
  logic              iss_use_scalar;
  valu_pkg::elen_t   iss_scalar;
  valu_pkg::vlen_t   iss_remaining;

  // Word under construction
  valu_pkg::elen_t   alu_result;
  valu_pkg::vaddr_t  word_addr;
  valu_pkg::strb_t   word_be;

  // Result queue feedback
  logic              rq_full;
  logic              rq_commit;

  valu_insn_queue #(
    .InsnQueueDepth (InsnQueueDepth)
  ) i_insn_queue (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .insn_valid_i      (insn_valid_i),
    .insn_op_i         (insn_op_i),
    .insn_vsew_i       (insn_vsew_i),
    .insn_vl_i         (insn_vl_i),
    .insn_vd_i         (insn_vd_i),
    .insn_id_i         (insn_id_i),
    .insn_vm_i         (insn_vm_i),
    .insn_use_scalar_i (insn_use_scalar_i),
    .insn_scalar_i     (insn_scalar_i),
    .insn_ready_o      (insn_ready_o),
    .operand_valid_i   (operand_valid_i),
    .operand_ready_o   (operand_ready_o),
    .mask_valid_i      (mask_valid_i),
    .mask_ready_o      (mask_ready_o),
    .rq_full_i         (rq_full),
    .commit_i          (rq_commit),
    .issue_o           (issue),
    .iss_op_o          (iss_op),
    .iss_vsew_o        (iss_vsew),
    .iss_vl_o          (iss_vl),
    .iss_vd_o          (iss_vd),
    .iss_id_o          (iss_id),
    .iss_vm_o          (iss_vm),
    .iss_use_scalar_o  (iss_use_scalar),
    .iss_scalar_o      (iss_scalar),
    .iss_remaining_o   (iss_remaining),
    .done_o            (done_o)
  );

  valu_simd_alu i_simd_alu (
    .op_i         (iss_op),
    .vsew_i       (iss_vsew),
    .use_scalar_i (iss_use_scalar),
    .scalar_i     (iss_scalar),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .result_o     (alu_result)
  );

  valu_word_tagger i_word_tagger (
    .vsew_i      (iss_vsew),
    .vl_i        (iss_vl),
    .remaining_i (iss_remaining),
    .vd_i        (iss_vd),
    .vm_i        (iss_vm),
    .mask_i      (mask_i),
    .addr_o      (word_addr),
    .be_o        (word_be)
  );

  valu_result_queue #(
    .ResultQueueDepth (ResultQueueDepth)
  ) i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (issue),
    .id_i           (iss_id),
    .addr_i         (word_addr),
    .wdata_i        (alu_result),
    .be_i           (word_be),
    .full_o         (rq_full),
    .commit_o       (rq_commit),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

// File: hw/valu_word_tagger.sv
module valu_word_tagger (
  input  valu_pkg::vew_e  vsew_i,
  input  valu_pkg::vlen_t vl_i,
  input  valu_pkg::vlen_t remaining_i,
  input  valu_pkg::vreg_t vd_i,
  input  logic            vm_i,
  input  valu_pkg::strb_t mask_i,
  output valu_pkg::vaddr_t addr_o,
  output valu_pkg::strb_t be_o
);

  valu_pkg::vlen_t epw;
  valu_pkg::vlen_t elem_cnt;
  valu_pkg::vlen_t nbytes;
  valu_pkg::vlen_t word_idx;
  valu_pkg::strb_t tail_be;

  //////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////

  always_comb begin : p_be
    epw = valu_pkg::elems_per_word(vsew_i);
    // Tail word carries fewer elements
    elem_cnt = (remaining_i < epw) ? remaining_i : epw;
    // Bytes per element is 1 << vsew, at most 8 bytes in total
    nbytes  = elem_cnt << vsew_i;
    tail_be = valu_pkg::strb_t'((16'd1 << nbytes) - 16'd1);
    // Masked elements lose their bytes
    be_o = vm_i ? tail_be : (tail_be & mask_i);
  end

  //////////////////////////////////////////////////
  // Destination address
  //////////////////////////////////////////////////

  always_comb begin : p_addr
    // Elements already issued, divided by elements per word
    word_idx = (vl_i - remaining_i) >> (2'd3 - vsew_i);
    addr_o   = valu_pkg::vaddr_t'(vd_i) * valu_pkg::vaddr_t'(valu_pkg::VRegWords) +
               valu_pkg::vaddr_t'(word_idx);
  end

endmodule

// File: test/tb_valu.sv
module tb_valu;

  localparam int ClkPeriod = 40;
  localparam int NOpsInsn  = 32;
  localparam int NInsn     = 38;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         insn_valid_i;
  valu_pkg::alu_op_e            insn_op_i;
  valu_pkg::vew_e               insn_vsew_i;
  valu_pkg::vlen_t              insn_vl_i;
  valu_pkg::vreg_t              insn_vd_i;
  valu_pkg::vid_t               insn_id_i;
  logic                         insn_vm_i;
  logic                         insn_use_scalar_i;
  valu_pkg::elen_t              insn_scalar_i;
  logic                         insn_ready_o;
  logic [valu_pkg::NrVInsn-1:0] done_o;
  valu_pkg::elen_t              operand_a_i;
  valu_pkg::elen_t              operand_b_i;
  logic [1:0]                   operand_valid_i;
  logic [1:0]                   operand_ready_o;
  valu_pkg::strb_t              mask_i;
  logic                         mask_valid_i;
  logic                         mask_ready_o;
  logic                         result_req_o;
  valu_pkg::vid_t               result_id_o;
  valu_pkg::vaddr_t             result_addr_o;
  valu_pkg::elen_t              result_wdata_o;
  valu_pkg::strb_t              result_be_o;
  logic                         result_gnt_i;

  // Instruction list, built before reset
  valu_pkg::alu_op_e op_a [NInsn];
  valu_pkg::vew_e    vsew_a [NInsn];
  int                vl_a [NInsn];
  int                vd_a [NInsn];
  logic              vm_a [NInsn];
  logic              use_scalar_a [NInsn];
  logic [63:0]       scalar_a [NInsn];

  // Expected words in issue order
  logic [63:0] exp_wdata [$];
  logic [7:0]  exp_be [$];
  logic [10:0] exp_addr [$];
  logic [2:0]  exp_id [$];
  logic        exp_last [$];

  integer seed = 32'h4d1d_8942;
  string  test_name = "reset";
  int     n_checks, n_errors, n_words, n_accepted, n_done, total_words;
  int     iss_idx, iss_rem;
  logic   list_ready, hold_gnt;

  valu_top #(
    .InsnQueueDepth   (4),
    .ResultQueueDepth (2)
  ) valu_top_i (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2);
      clk_i = ~clk_i;
    end
  end

  //////////////////////////////////////////////////
  // Reference rules
  //////////////////////////////////////////////////

  function automatic logic [63:0] lane_op(valu_pkg::alu_op_e op, logic [63:0] x,
                                          logic [63:0] y);
    case (op)
      valu_pkg::VADD:  return x + y;
      valu_pkg::VSUB:  return y - x;
      valu_pkg::VRSUB: return x - y;
      valu_pkg::VAND:  return x & y;
      valu_pkg::VOR:   return x | y;
      valu_pkg::VXOR:  return x ^ y;
      valu_pkg::VMINU: return (x < y) ? x : y;
      default:         return (x > y) ? x : y;
    endcase
  endfunction

  // Lane by lane; scalar element stands in for every a element
  function automatic logic [63:0] ref_word(valu_pkg::alu_op_e op, int sew, logic scal,
                                           logic [63:0] scalar, logic [63:0] a,
                                           logic [63:0] b);
    int          w;
    logic [63:0] lmask, ea, eb, res;
    w     = 8 << sew;
    lmask = {64{1'b1}} >> (64 - w);
    res   = '0;
    for (int e = 0; e < (8 >> sew); e++) begin
      ea  = scal ? (scalar & lmask) : ((a >> (e * w)) & lmask);
      eb  = (b >> (e * w)) & lmask;
      res = res | ((lane_op(op, ea, eb) & lmask) << (e * w));
    end
    return res;
  endfunction

  // Tail elements first, then the mask when vm is low
  function automatic logic [7:0] ref_be(int sew, int rem, logic vm, logic [7:0] mask);
    int         cnt;
    logic [7:0] be;
    cnt = (rem < (8 >> sew)) ? rem : (8 >> sew);
    for (int k = 0; k < 8; k++) begin
      be[k] = (k / (1 << sew)) < cnt;
    end
    return vm ? be : (be & mask);
  endfunction

  task automatic check_value(string what, logic [63:0] exp, logic [63:0] act);
    n_checks++;
    assert (exp === act) else begin
      n_errors++;
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Operands and mask change only once consumed or while not valid
  always @(posedge clk_i) begin : operand_drive
    if (rst_ni) begin
      if (operand_ready_o[0] || !operand_valid_i[0]) begin
        operand_a_i        <= {$random(seed), $random(seed)};
        operand_valid_i[0] <= ($random(seed) & 3) != 0;
      end
      if (operand_ready_o[1] || !operand_valid_i[1]) begin
        operand_b_i        <= {$random(seed), $random(seed)};
        operand_valid_i[1] <= ($random(seed) & 3) != 0;
      end
      if (mask_ready_o || !mask_valid_i) begin
        mask_i       <= 8'($random(seed));
        mask_valid_i <= ($random(seed) & 3) != 0;
      end
      result_gnt_i <= hold_gnt ? 1'b0 : (($random(seed) & 3) != 0);
    end
  end

  // Called on a rising edge, returns on the edge that accepts it
  task automatic send_insn(int k);
    insn_valid_i      <= 1'b1;
    insn_op_i         <= op_a[k];
    insn_vsew_i       <= vsew_a[k];
    insn_vl_i         <= valu_pkg::vlen_t'(vl_a[k]);
    insn_vd_i         <= valu_pkg::vreg_t'(vd_a[k]);
    insn_id_i         <= valu_pkg::vid_t'(k % 8);
    insn_vm_i         <= vm_a[k];
    insn_use_scalar_i <= use_scalar_a[k];
    insn_scalar_i     <= scalar_a[k];
    @(posedge clk_i);
    while (!insn_ready_o) begin
      @(posedge clk_i);
    end
  endtask

  // All ops at all widths first, then a random tail for back-pressure
  task automatic build_list();
    int epw;
    for (int k = 0; k < NInsn; k++) begin
      op_a[k]         = valu_pkg::alu_op_e'(k < NOpsInsn ? k % 8 : $random(seed) & 7);
      vsew_a[k]       = valu_pkg::vew_e'(k < NOpsInsn ? k / 8 : $random(seed) & 3);
      epw             = 8 >> int'(vsew_a[k]);
      vl_a[k]         = 1 + ($unsigned($random(seed)) % 40);
      // Some lengths fill whole words
      if (k % 7 == 0) begin
        vl_a[k] = 3 * epw;
      end
      vd_a[k]         = $random(seed) & 31;
      vm_a[k]         = (k % 3) != 0;
      use_scalar_a[k] = (k % 4) >= 2;
      scalar_a[k]     = {$random(seed), $random(seed)};
      total_words    += (vl_a[k] + epw - 1) / epw;
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : model
    logic [7:0]  exp_done;
    logic        hold_prev;
    logic [63:0] prev_wdata;
    logic [31:0] prev_tag;
    int          epw;
    if (rst_ni) begin
      exp_done = '0;
      check_value("insn_ready", (n_accepted - n_done) != 4, insn_ready_o);
      if (insn_valid_i && insn_ready_o) begin
        n_accepted++;
      end
      // Fields stay put while the write waits for its grant
      if (hold_prev) begin
        check_value("req_held", 1'b1, result_req_o);
        check_value("held_wdata", prev_wdata, result_wdata_o);
        check_value("held_tag", prev_tag, {result_id_o, result_addr_o, result_be_o});
      end
      hold_prev  = result_req_o && !result_gnt_i;
      prev_wdata = result_wdata_o;
      prev_tag   = {result_id_o, result_addr_o, result_be_o};
      if (result_req_o && result_gnt_i) begin
        if (exp_wdata.size() == 0) begin
          n_errors++;
          $display("Write granted with no word outstanding in %s", test_name);
        end else begin
          check_value("wdata", exp_wdata.pop_front(), result_wdata_o);
          check_value("be", exp_be.pop_front(), result_be_o);
          check_value("addr", exp_addr.pop_front(), result_addr_o);
          check_value("id", exp_id[0], result_id_o);
          if (exp_last.pop_front()) begin
            exp_done[exp_id[0]] = 1'b1;
            n_done++;
          end
          void'(exp_id.pop_front());
          n_words++;
        end
      end
      check_value("done", exp_done, done_o);
      if (operand_ready_o[1]) begin
        if (iss_rem == 0) begin
          iss_rem = vl_a[iss_idx];
        end
        epw = 8 >> int'(vsew_a[iss_idx]);
        check_value("operand_valid", 3'b111, {operand_valid_i[1],
          operand_valid_i[0] || use_scalar_a[iss_idx], mask_valid_i || vm_a[iss_idx]});
        check_value("a_ready", !use_scalar_a[iss_idx], operand_ready_o[0]);
        check_value("mask_ready", !vm_a[iss_idx], mask_ready_o);
        exp_wdata.push_back(ref_word(op_a[iss_idx], int'(vsew_a[iss_idx]),
                                     use_scalar_a[iss_idx], scalar_a[iss_idx],
                                     operand_a_i, operand_b_i));
        exp_be.push_back(ref_be(int'(vsew_a[iss_idx]), iss_rem, vm_a[iss_idx], mask_i));
        exp_addr.push_back(11'(vd_a[iss_idx] * valu_pkg::VRegWords +
                               (vl_a[iss_idx] - iss_rem) / epw));
        exp_id.push_back(3'(iss_idx % 8));
        iss_rem = iss_rem - ((iss_rem < epw) ? iss_rem : epw);
        exp_last.push_back(iss_rem == 0);
        if (iss_rem == 0) begin
          iss_idx++;
        end
      end else begin
        check_value("idle_ready", 3'b000, {operand_ready_o, mask_ready_o});
      end
    end
  end

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin : main
    rst_ni = 1'b0;
    insn_valid_i = 1'b0;
    insn_op_i = valu_pkg::VADD;
    insn_vsew_i = valu_pkg::EW8;
    insn_vl_i = '0;
    insn_vd_i = '0;
    insn_id_i = '0;
    insn_vm_i = 1'b1;
    insn_use_scalar_i = 1'b0;
    insn_scalar_i = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_valid_i = 2'b00;
    mask_i = '0;
    mask_valid_i = 1'b0;
    result_gnt_i = 1'b0;
    hold_gnt = 1'b0;
    build_list();
    list_ready = 1'b1;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_value("reset_outputs", 13'h1000,
                {insn_ready_o, result_req_o, operand_ready_o, mask_ready_o, done_o});
    test_name = "ops_widths";
    for (int k = 0; k < NOpsInsn; k++) begin
      send_insn(k);
    end
    insn_valid_i <= 1'b0;
    while (n_done < NOpsInsn) @(posedge clk_i);
    // Grants held low until the instruction queue fills up
    test_name = "backpressure";
    hold_gnt <= 1'b1;
    fork
      begin
        for (int k = NOpsInsn; k < NInsn; k++) begin
          send_insn(k);
        end
        insn_valid_i <= 1'b0;
      end
      begin
        while (insn_ready_o) @(posedge clk_i);
        repeat (10) @(posedge clk_i);
        check_value("stalled_req", 1'b1, result_req_o);
        hold_gnt <= 1'b0;
      end
    join
    while (n_done < NInsn) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    if (exp_wdata.size() != 0 || iss_idx != NInsn) begin
      n_errors++;
      $display("Words left unwritten: %0d, instructions issued: %0d", exp_wdata.size(),
               iss_idx);
    end
    $display("Checks: %0d  errors: %0d  words: %0d  instructions: %0d", n_checks, n_errors,
             n_words, n_done);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Forty cycles per word is far beyond any legal latency
  initial begin : watchdog
    wait (list_ready === 1'b1);
    #(total_words * 40 * ClkPeriod + 200 * ClkPeriod);
    $display("Timeout: run did not finish, %0d of %0d instructions done", n_done, NInsn);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: vlog.f
hw/valu_pkg.sv
hw/valu_insn_queue.sv
hw/valu_simd_alu.sv
hw/valu_word_tagger.sv
hw/valu_result_queue.sv
hw/valu_top.sv
test/tb_valu.sv
